// File: Bender.yml
package:
  name: la_core

sources:
  - design/isa_pkg.sv
  - design/pipe_pkg.sv
  - design/regfile.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/mem_wb_stage.sv
  - design/mem_arbiter.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - tests/cpu_tb.sv

// File: all.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/mem_arbiter.sv
design/cpu_top.sv
tests/cpu_tb.sv

// File: design/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
    parameter isa_pkg::word_t reset_pc = 32'h0
) (
    input  logic               clk,
    input  logic               reset,
    output pipe_pkg::mem_req_t mem_bus,
    input  isa_pkg::word_t     mem_rdata,
    output isa_pkg::word_t     debug_wb_pc,
    output isa_pkg::word_t     debug_wb_data,
    output logic               debug_wb_we,
    output isa_pkg::reg_idx_t  debug_wb_num
);

    logic                ds_allowin;
    logic                es_allowin;
    logic                ms_allowin;
    logic                fs_to_ds_valid;
    logic                ds_to_es_valid;
    logic                es_to_ms_valid;
    pipe_pkg::fs_to_ds_t fs_to_ds_bus;
    pipe_pkg::ds_to_es_t ds_to_es_bus;
    pipe_pkg::es_to_ms_t es_to_ms_bus;
    pipe_pkg::br_t       br;
    pipe_pkg::fwd_t      es_fwd;
    pipe_pkg::fwd_t      ms_fwd;
    pipe_pkg::fwd_t      ws_fwd;
    pipe_pkg::mem_req_t  fetch_req;
    pipe_pkg::mem_req_t  data_req;
    logic                fetch_gnt;
    logic                fetch_rdata_valid;
    logic                data_rdata_valid;
    isa_pkg::word_t      fetch_rdata;
    isa_pkg::word_t      data_rdata;
    isa_pkg::reg_idx_t   rf_raddr1;
    isa_pkg::reg_idx_t   rf_raddr2;
    isa_pkg::word_t      rf_rdata1;
    isa_pkg::word_t      rf_rdata2;
    logic                rf_we;
    isa_pkg::reg_idx_t   rf_waddr;
    isa_pkg::word_t      rf_wdata;

    fetch_stage #(.reset_pc(reset_pc)) fetch_i (
        .clk, .reset, .br, .ds_allowin, .fs_to_ds_valid, .fs_to_ds_bus,
        .fetch_req, .fetch_gnt, .fetch_rdata, .fetch_rdata_valid
    );

    decode_stage decode_i (
        .clk, .reset, .fs_to_ds_valid, .fs_to_ds_bus, .ds_allowin, .es_allowin,
        .ds_to_es_valid, .ds_to_es_bus, .br, .es_fwd, .ms_fwd, .ws_fwd,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2
    );

    execute_stage execute_i (
        .clk, .reset, .ds_to_es_valid, .ds_to_es_bus, .es_allowin, .ms_allowin,
        .es_to_ms_valid, .es_to_ms_bus, .es_fwd
    );

    mem_wb_stage mem_wb_i (
        .clk, .reset, .es_to_ms_valid, .es_to_ms_bus, .ms_allowin,
        .data_req, .data_rdata, .data_rdata_valid, .ms_fwd, .ws_fwd,
        .rf_we, .rf_waddr, .rf_wdata,
        .debug_wb_pc, .debug_wb_data, .debug_wb_we, .debug_wb_num
    );

    regfile regfile_i (
        .clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
        .rdata2(rf_rdata2), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    mem_arbiter arbiter_i (
        .clk, .reset, .fetch_req, .fetch_gnt, .fetch_rdata, .fetch_rdata_valid,
        .data_req, .data_rdata, .data_rdata_valid, .mem_bus, .mem_rdata
    );

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                fs_to_ds_valid,
    input  pipe_pkg::fs_to_ds_t fs_to_ds_bus,
    output logic                ds_allowin,
    input  logic                es_allowin,
    output logic                ds_to_es_valid,
    output pipe_pkg::ds_to_es_t ds_to_es_bus,
    output pipe_pkg::br_t       br,
    input  pipe_pkg::fwd_t      es_fwd,
    input  pipe_pkg::fwd_t      ms_fwd,
    input  pipe_pkg::fwd_t      ws_fwd,
    output isa_pkg::reg_idx_t   rf_raddr1,
    output isa_pkg::reg_idx_t   rf_raddr2,
    input  isa_pkg::word_t      rf_rdata1,
    input  isa_pkg::word_t      rf_rdata2
);

    logic                ds_valid;
    logic                ds_ready_go;
    pipe_pkg::fs_to_ds_t ds_bus;
    isa_pkg::word_t      inst;
    isa_pkg::word_t      pc;
    isa_pkg::word_t      imm;
    isa_pkg::word_t      val1;
    isa_pkg::word_t      val2;
    isa_pkg::alu_op_t    alu_op;
    logic                inst_add_w;
    logic                inst_sub_w;
    logic                inst_and;
    logic                inst_or;
    logic                inst_xor;
    logic                inst_addi_w;
    logic                inst_andi;
    logic                inst_ori;
    logic                inst_lu12i_w;
    logic                inst_ld_w;
    logic                inst_st_w;
    logic                inst_b;
    logic                inst_bl;
    logic                inst_beq;
    logic                inst_bne;
    logic is_3r;
    logic is_cbr;
    logic use1;
    logic use2;
    logic load_stall;
    logic br_taken;

    function automatic logic fwd_hit(pipe_pkg::fwd_t f, isa_pkg::reg_idx_t idx);
        return f.valid && f.gr_we && (f.dest == idx) && (idx != 5'd0);
    endfunction

    // nearest older writer wins
    function automatic isa_pkg::word_t fwd_value(isa_pkg::reg_idx_t idx,
                                                 isa_pkg::word_t rf_val);
        if (fwd_hit(es_fwd, idx))
            return es_fwd.value;
        if (fwd_hit(ms_fwd, idx))
            return ms_fwd.value;
        if (fwd_hit(ws_fwd, idx))
            return ws_fwd.value;
        return rf_val;
    endfunction

    // a load value only exists once the load reaches writeback
    function automatic logic load_hit(isa_pkg::reg_idx_t idx);
        return (fwd_hit(es_fwd, idx) && es_fwd.is_load) ||
               (!fwd_hit(es_fwd, idx) && fwd_hit(ms_fwd, idx) && ms_fwd.is_load);
    endfunction

    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // a taken branch kills the word behind it
            ds_valid <= fs_to_ds_valid && !br_taken;
        end
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    assign inst = ds_bus.inst;
    assign pc   = ds_bus.pc;

    assign inst_add_w   = inst[31:15] == isa_pkg::OP_ADD_W;
    assign inst_sub_w   = inst[31:15] == isa_pkg::OP_SUB_W;
    assign inst_and     = inst[31:15] == isa_pkg::OP_AND;
    assign inst_or      = inst[31:15] == isa_pkg::OP_OR;
    assign inst_xor     = inst[31:15] == isa_pkg::OP_XOR;
    assign inst_addi_w  = inst[31:22] == isa_pkg::OP_ADDI_W;
    assign inst_andi    = inst[31:22] == isa_pkg::OP_ANDI;
    assign inst_ori     = inst[31:22] == isa_pkg::OP_ORI;
    assign inst_ld_w    = inst[31:22] == isa_pkg::OP_LD_W;
    assign inst_st_w    = inst[31:22] == isa_pkg::OP_ST_W;
    assign inst_lu12i_w = inst[31:25] == isa_pkg::OP_LU12I_W;
    assign inst_b       = inst[31:26] == isa_pkg::OP_B;
    assign inst_bl      = inst[31:26] == isa_pkg::OP_BL;
    assign inst_beq     = inst[31:26] == isa_pkg::OP_BEQ;
    assign inst_bne     = inst[31:26] == isa_pkg::OP_BNE;

    assign is_3r  = inst_add_w || inst_sub_w || inst_and || inst_or || inst_xor;
    assign is_cbr = inst_beq || inst_bne;

    always_comb begin
        if (inst_sub_w)
            alu_op = isa_pkg::ALU_SUB;
        else if (inst_and || inst_andi)
            alu_op = isa_pkg::ALU_AND;
        else if (inst_or || inst_ori)
            alu_op = isa_pkg::ALU_OR;
        else if (inst_xor)
            alu_op = isa_pkg::ALU_XOR;
        else if (inst_lu12i_w)
            alu_op = isa_pkg::ALU_LUI;
        else
            alu_op = isa_pkg::ALU_ADD;
    end

    // si12, ui12, si20, offs16, offs26
    assign imm = (inst_addi_w || inst_ld_w || inst_st_w) ? {{20{inst[21]}}, inst[21:10]} :
                 (inst_andi || inst_ori)                 ? {20'd0, inst[21:10]} :
                 inst_lu12i_w                            ? {inst[24:5], 12'd0} :
                 is_cbr                                  ? {{14{inst[25]}}, inst[25:10], 2'b00} :
                 {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    // stores and compares read rd as the second source
    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = (inst_st_w || is_cbr) ? inst[4:0] : inst[14:10];
    assign use1      = !(inst_lu12i_w || inst_b || inst_bl);
    assign use2      = is_3r || inst_st_w || is_cbr;

    always_comb begin
        val1       = fwd_value(rf_raddr1, rf_rdata1);
        val2       = fwd_value(rf_raddr2, rf_rdata2);
        load_stall = ds_valid && ((use1 && load_hit(rf_raddr1)) ||
                                  (use2 && load_hit(rf_raddr2)));
    end

    always_comb begin
        ds_to_es_bus.pc       = pc;
        ds_to_es_bus.alu_op   = alu_op;
        ds_to_es_bus.src1     = inst_bl ? pc : val1;
        ds_to_es_bus.src2     = inst_bl ? 32'd4 : (is_3r ? val2 : imm);
        ds_to_es_bus.st_data  = val2;
        ds_to_es_bus.dest     = inst_bl ? isa_pkg::REG_RA : inst[4:0];
        ds_to_es_bus.gr_we    = is_3r || inst_addi_w || inst_andi || inst_ori ||
                                inst_lu12i_w || inst_ld_w || inst_bl;
        ds_to_es_bus.is_load  = inst_ld_w;
        ds_to_es_bus.is_store = inst_st_w;
    end

    // resolved here, only as the branch leaves for execute
    assign br_taken = ds_to_es_valid && es_allowin &&
                      (inst_b || inst_bl ||
                       (inst_beq && (val1 == val2)) ||
                       (inst_bne && (val1 != val2)));

    assign br.taken  = br_taken;
    assign br.target = pc + imm;

    // a load still in execute has no value to hand over yet
    a_no_issue_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        ds_to_es_valid |-> !(es_fwd.valid && es_fwd.gr_we && es_fwd.is_load &&
                             (es_fwd.dest != 5'd0) &&
                             ((use1 && (es_fwd.dest == rf_raddr1)) ||
                              (use2 && (es_fwd.dest == rf_raddr2))))
    ) else $error("decode issued during a load-use stall");

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ds_to_es_valid,
    input  pipe_pkg::ds_to_es_t ds_to_es_bus,
    output logic                es_allowin,
    input  logic                ms_allowin,
    output logic                es_to_ms_valid,
    output pipe_pkg::es_to_ms_t es_to_ms_bus,
    output pipe_pkg::fwd_t      es_fwd
);

    logic                es_valid;
    logic                es_ready_go;
    pipe_pkg::ds_to_es_t es_bus;
    isa_pkg::word_t      alu_result;

    // single-cycle ALU
    assign es_ready_go    = 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            es_bus <= ds_to_es_bus;
        end
    end

    always_comb begin
        case (es_bus.alu_op)
            isa_pkg::ALU_SUB: alu_result = es_bus.src1 - es_bus.src2;
            isa_pkg::ALU_AND: alu_result = es_bus.src1 & es_bus.src2;
            isa_pkg::ALU_OR:  alu_result = es_bus.src1 | es_bus.src2;
            isa_pkg::ALU_XOR: alu_result = es_bus.src1 ^ es_bus.src2;
            isa_pkg::ALU_LUI: alu_result = es_bus.src2;
            default:          alu_result = es_bus.src1 + es_bus.src2;
        endcase
    end

    always_comb begin
        es_to_ms_bus.pc       = es_bus.pc;
        es_to_ms_bus.result   = alu_result;
        es_to_ms_bus.st_data  = es_bus.st_data;
        es_to_ms_bus.dest     = es_bus.dest;
        es_to_ms_bus.gr_we    = es_bus.gr_we;
        es_to_ms_bus.is_load  = es_bus.is_load;
        es_to_ms_bus.is_store = es_bus.is_store;
    end

    assign es_fwd = '{valid: es_valid, gr_we: es_bus.gr_we, is_load: es_bus.is_load,
                      dest: es_bus.dest, value: alu_result};

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter isa_pkg::word_t reset_pc = 32'h0
) (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::br_t       br,
    input  logic                ds_allowin,
    output logic                fs_to_ds_valid,
    output pipe_pkg::fs_to_ds_t fs_to_ds_bus,
    output pipe_pkg::mem_req_t  fetch_req,
    input  logic                fetch_gnt,
    input  isa_pkg::word_t      fetch_rdata,
    input  logic                fetch_rdata_valid
);

    logic           started;
    logic           fs_valid;
    logic           fs_allowin;
    isa_pkg::word_t pc;
    isa_pkg::word_t fs_pc;
    isa_pkg::word_t inst_hold;

    // the word lands one cycle after its grant, so a valid slot always has data
    assign fs_allowin = !fs_valid || ds_allowin;

    assign fetch_req.req   = started && fs_allowin;
    assign fetch_req.we    = 1'b0;
    assign fetch_req.addr  = pc;
    assign fetch_req.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            started  <= 1'b0;
            fs_valid <= 1'b0;
            pc       <= reset_pc;
        end else begin
            started <= 1'b1;
            // redirect empties the slot, so a read granted now returns to nothing
            if (br.taken) begin
                fs_valid <= 1'b0;
                pc       <= br.target;
            end else begin
                if (fs_allowin) begin
                    fs_valid <= fetch_gnt;
                end
                if (fetch_gnt) begin
                    pc <= pc + 32'd4;
                end
            end
        end
        if (fetch_gnt) begin
            fs_pc <= pc;
        end
        if (fetch_rdata_valid) begin
            inst_hold <= fetch_rdata;
        end
    end

    assign fs_to_ds_valid    = fs_valid;
    assign fs_to_ds_bus.pc   = fs_pc;
    assign fs_to_ds_bus.inst = fetch_rdata_valid ? fetch_rdata : inst_hold;

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_t;

    // 3R format, matched on inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 format, matched on inst[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // 1RI20 format, inst[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // branches, inst[31:26]
    localparam logic [5:0] OP_B   = 6'h14;
    localparam logic [5:0] OP_BL  = 6'h15;
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;

    // link register written by bl
    localparam reg_idx_t REG_RA = 5'd1;

endpackage

// File: design/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  pipe_pkg::mem_req_t fetch_req,
    output logic               fetch_gnt,
    output isa_pkg::word_t     fetch_rdata,
    output logic               fetch_rdata_valid,
    input  pipe_pkg::mem_req_t data_req,
    output isa_pkg::word_t     data_rdata,
    output logic               data_rdata_valid,
    output pipe_pkg::mem_req_t mem_bus,
    input  isa_pkg::word_t     mem_rdata
);

    logic data_gnt;
    logic pend_fetch;
    logic pend_data;

    // memory stage has fixed priority
    assign data_gnt  = data_req.req;
    assign fetch_gnt = fetch_req.req && !data_gnt;
    assign mem_bus   = data_gnt ? data_req : fetch_req;

    // owner of the read whose data shows up next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_fetch <= 1'b0;
            pend_data  <= 1'b0;
        end else begin
            pend_fetch <= fetch_gnt && !fetch_req.we;
            pend_data  <= data_gnt && !data_req.we;
        end
    end

    assign fetch_rdata       = mem_rdata;
    assign fetch_rdata_valid = pend_fetch;
    assign data_rdata        = mem_rdata;
    assign data_rdata_valid  = pend_data;

    a_bus_req_known: assert property (
        @(posedge clk) disable iff (reset)
        mem_bus.req |-> !$isunknown({mem_bus.we, mem_bus.addr})
    ) else $error("bus request with unknown address or direction");

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                es_to_ms_valid,
    input  pipe_pkg::es_to_ms_t es_to_ms_bus,
    output logic                ms_allowin,
    output pipe_pkg::mem_req_t  data_req,
    input  isa_pkg::word_t      data_rdata,
    input  logic                data_rdata_valid,
    output pipe_pkg::fwd_t      ms_fwd,
    output pipe_pkg::fwd_t      ws_fwd,
    output logic                rf_we,
    output isa_pkg::reg_idx_t   rf_waddr,
    output isa_pkg::word_t      rf_wdata,
    output isa_pkg::word_t      debug_wb_pc,
    output isa_pkg::word_t      debug_wb_data,
    output logic                debug_wb_we,
    output isa_pkg::reg_idx_t   debug_wb_num
);

    logic                ms_valid;
    logic                ws_valid;
    logic                ws_allowin;
    pipe_pkg::es_to_ms_t ms_bus;
    pipe_pkg::es_to_ms_t ws_bus;
    isa_pkg::word_t      ws_result;

    // data requests always win the bus, so neither latch ever holds
    assign ws_allowin = 1'b1;
    assign ms_allowin = !ms_valid || ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
            ws_valid <= 1'b0;
        end else begin
            if (ms_allowin)
                ms_valid <= es_to_ms_valid;
            if (ws_allowin)
                ws_valid <= ms_valid;
        end
        if (es_to_ms_valid && ms_allowin)
            ms_bus <= es_to_ms_bus;
        if (ms_valid && ws_allowin)
            ws_bus <= ms_bus;
    end

    // one request per memory op, in its only memory-stage cycle
    assign data_req.req   = ms_valid && (ms_bus.is_load || ms_bus.is_store);
    assign data_req.we    = ms_valid && ms_bus.is_store;
    assign data_req.addr  = ms_bus.result;
    assign data_req.wdata = ms_bus.st_data;

    assign ws_result = ws_bus.is_load ? data_rdata : ws_bus.result;

    assign ms_fwd = '{valid: ms_valid, gr_we: ms_bus.gr_we, is_load: ms_bus.is_load,
                      dest: ms_bus.dest, value: ms_bus.result};
    assign ws_fwd = '{valid: ws_valid, gr_we: ws_bus.gr_we, is_load: ws_bus.is_load,
                      dest: ws_bus.dest, value: ws_result};

    assign rf_we    = ws_valid && ws_bus.gr_we;
    assign rf_waddr = ws_bus.dest;
    assign rf_wdata = ws_result;

    assign debug_wb_we   = rf_we && (ws_bus.dest != 5'd0);
    assign debug_wb_pc   = ws_bus.pc;
    assign debug_wb_data = ws_result;
    assign debug_wb_num  = ws_bus.dest;

    a_load_data_ready: assert property (
        @(posedge clk) disable iff (reset) (ws_valid && ws_bus.is_load) |-> data_rdata_valid
    ) else $error("load in writeback without read data");

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fs_to_ds_t;

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::alu_op_t  alu_op;
        isa_pkg::word_t    src1;
        isa_pkg::word_t    src2;
        isa_pkg::word_t    st_data;
        isa_pkg::reg_idx_t dest;
        logic              gr_we;
        logic              is_load;
        logic              is_store;
    } ds_to_es_t;

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::word_t    result;
        isa_pkg::word_t    st_data;
        isa_pkg::reg_idx_t dest;
        logic              gr_we;
        logic              is_load;
        logic              is_store;
    } es_to_ms_t;

    // view of an in-flight writer, as seen by decode
    typedef struct packed {
        logic              valid;
        logic              gr_we;
        logic              is_load;
        isa_pkg::reg_idx_t dest;
        isa_pkg::word_t    value;
    } fwd_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } br_t;

    typedef struct packed {
        logic           req;
        logic           we;
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
    } mem_req_t;

endpackage

// File: design/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic              clk,
    input  isa_pkg::reg_idx_t raddr1,
    input  isa_pkg::reg_idx_t raddr2,
    output isa_pkg::word_t    rdata1,
    output isa_pkg::word_t    rdata2,
    input  logic              we,
    input  isa_pkg::reg_idx_t waddr,
    input  isa_pkg::word_t    wdata
);

    isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr))
        else $error("regfile write with unknown address");

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

    localparam isa_pkg::word_t reset_pc = 32'h0;
    localparam int mem_words = 256;
    localparam int vec_words = 512;
    localparam int trace_base = 256;
    localparam int retire_timeout = 200;
    localparam int quiet_cycles = 50;

    logic               clk = 1'b0;
    logic               reset;
    pipe_pkg::mem_req_t mem_bus;
    isa_pkg::word_t     mem_rdata;
    isa_pkg::word_t     debug_wb_pc;
    isa_pkg::word_t     debug_wb_data;
    logic               debug_wb_we;
    isa_pkg::reg_idx_t  debug_wb_num;

    isa_pkg::word_t mem [mem_words];
    isa_pkg::word_t vec [vec_words];
    isa_pkg::word_t read_data_next;

    cpu_top #(.reset_pc(reset_pc)) dut_i (
        .clk, .reset, .mem_bus, .mem_rdata,
        .debug_wb_pc, .debug_wb_data, .debug_wb_we, .debug_wb_num
    );

    always begin
        #2 clk = ~clk;
    end

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t ns signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
            fail_now();
        end
    endtask

    // program words go into the memory model, the rest stays in vec
    task automatic load_vectors(output int trace_count);
        for (int i = 0; i < vec_words; i++) begin
            vec[i] = 'x;
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i * 4);
        end
        $readmemh("tests/program_vectors.txt", vec);
        for (int i = 0; i < trace_base; i++) begin
            if (!$isunknown(vec[i])) begin
                mem[i] = vec[i];
            end
        end
        if ($isunknown(vec[trace_base])) begin
            $display("the vectors file holds no trace entry count");
            fail_now();
        end else begin
            trace_count = vec[trace_base];
        end
    endtask

    task automatic wait_for_retire(input int entry);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (debug_wb_we !== 1'b1) begin
            if (cycles >= retire_timeout) begin
                $display("timeout: the core stopped retiring before trace entry %0d", entry);
                fail_now();
            end else begin
                cycles = cycles + 1;
                @(posedge clk);
            end
        end
    endtask

    // read data shows up one cycle after the request
    always @(negedge clk) begin
        mem_rdata = read_data_next;
        if (mem_bus.req === 1'b1) begin
            if (mem_bus.addr >= mem_words * 4) begin
                $display("memory access outside the model at address 0x%08h", mem_bus.addr);
                fail_now();
            end else if (mem_bus.we) begin
                mem[mem_bus.addr[9:2]] = mem_bus.wdata;
            end else begin
                read_data_next = mem[mem_bus.addr[9:2]];
            end
        end
    end

    initial begin
        int trace_count;
        int base;

        reset = 1'b1;
        mem_rdata = '0;
        read_data_next = '0;
        load_vectors(trace_count);

        // trace must stay quiet through reset
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_value("debug_wb_we", 32'd0, debug_wb_we);
            end
        end
        @(negedge clk);
        reset = 1'b0;

        for (int n = 0; n < trace_count; n++) begin
            base = trace_base + 1 + 3 * n;
            wait_for_retire(n);
            if (n == 0) begin
                check_value("debug_wb_pc", reset_pc, debug_wb_pc);
            end
            check_value("debug_wb_pc", vec[base], debug_wb_pc);
            check_value("debug_wb_num", vec[base + 1], debug_wb_num);
            check_value("debug_wb_data", vec[base + 2], debug_wb_data);
        end

        // program now spins on its final branch
        for (int i = 0; i < quiet_cycles; i++) begin
            @(posedge clk);
            check_value("debug_wb_we", 32'd0, debug_wb_we);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tests/program_vectors.txt
// @000: program image, one instruction word per line (word index = byte address / 4)
// @100: number of trace entries, then one entry per line: pc, register number, value
@000
02801401 // 00 addi.w r1, r0, 5
02BFF402 // 04 addi.w r2, r0, -3
00100823 // 08 add.w  r3, r1, r2
00110464 // 0c sub.w  r4, r3, r1
142468A5 // 10 lu12i.w r5, 0x12345
0399E0A5 // 14 ori    r5, r5, 0x678
001590A6 // 18 xor    r6, r5, r4
037FC0C7 // 1c andi   r7, r6, 0xff0
02840008 // 20 addi.w r8, r0, 0x100
29800105 // 24 st.w   r5, r8, 0
28800109 // 28 ld.w   r9, r8, 0
0010052A // 2c add.w  r10, r9, r1
2980110A // 30 st.w   r10, r8, 4
2880110B // 34 ld.w   r11, r8, 4
5800096A // 38 beq    r11, r10, 0x40
029FFC0C // 3c addi.w r12, r0, 0x7ff (skipped)
5C000821 // 40 bne    r1, r1, 0x48 (falls through)
54000800 // 44 bl     0x4c
0280040D // 48 addi.w r13, r0, 1 (skipped)
00151C2E // 4c or     r14, r1, r7
5C0009C0 // 50 bne    r14, r0, 0x58
0280080F // 54 addi.w r15, r0, 2 (skipped)
0014B92F // 58 and    r15, r9, r14
50000000 // 5c b      0x5c
@100
0000000F
00000000 01 00000005
00000004 02 FFFFFFFD
00000008 03 00000002
0000000C 04 FFFFFFFD
00000010 05 12345000
00000014 05 12345678
00000018 06 EDCBA985
0000001C 07 00000980
00000020 08 00000100
00000028 09 12345678
0000002C 0A 1234567D
00000034 0B 1234567D
00000044 01 00000048
0000004C 0E 000009C8
00000058 0F 00000048
